/* hdl/fc_layer.sv */
//////////////////////////////////////////////////
// FC layer engine top level: configuration,
// stream loader, six word memories, compute
// sequencer and output packer
//////////////////////////////////////////////////

module fc_layer (
  input  logic          clk,
  input  logic          rstn,
  input  fc_pkg::word_t s_tdata,
  input  logic          s_tvalid,
  output logic          s_tready,
  output fc_pkg::word_t m_tdata,
  output logic          m_tvalid,
  input  logic          m_tready,
  output logic          m_tlast,
  input  logic [2:0]    command,
  input  logic          fc_start,
  input  fc_pkg::size_t size,
  output logic          f_done,
  output logic          b_done,
  output logic          w_done,
  output logic          fc_done,
  output fc_pkg::idx_t  max_idx
);
  import fc_pkg::*;

  load_mode_t       load_mode;
  size_t            feat_count;
  size_t            out_count;
  logic             load_finish;
  logic             compute_go;
  logic             run_finish;
  addr_t            rd_addr;
  addr_t            mem_addr;
  word_t            wdata;
  logic             feat_we;
  logic             bias_we;
  logic [LANES-1:0] wt_we;
  word_t            feat_rdata;
  word_t            bias_rdata;
  wire word_t       wt_rdata [LANES];

  fc_result_if res_if ();

  layer_config u_config (
    .clk         (clk),
    .rstn        (rstn),
    .command     (command),
    .fc_start    (fc_start),
    .size        (size),
    .load_finish (load_finish),
    .run_finish  (run_finish),
    .load_mode   (load_mode),
    .feat_count  (feat_count),
    .out_count   (out_count),
    .compute_go  (compute_go),
    .f_done      (f_done),
    .b_done      (b_done),
    .w_done      (w_done),
    .fc_done     (fc_done)
  );

  stream_loader u_loader (
    .clk         (clk),
    .rstn        (rstn),
    .s_tdata     (s_tdata),
    .s_tvalid    (s_tvalid),
    .s_tready    (s_tready),
    .load_mode   (load_mode),
    .feat_count  (feat_count),
    .out_count   (out_count),
    .rd_addr     (rd_addr),
    .load_finish (load_finish),
    .mem_addr    (mem_addr),
    .wdata       (wdata),
    .feat_we     (feat_we),
    .bias_we     (bias_we),
    .wt_we       (wt_we)
  );

  ////////////////////////////////////////////////////
  // Memories
  ////////////////////////////////////////////////////

  word_mem u_feat_mem (
    .clk   (clk),
    .we    (feat_we),
    .addr  (mem_addr),
    .wdata (wdata),
    .rdata (feat_rdata)
  );

  word_mem u_bias_mem (
    .clk   (clk),
    .we    (bias_we),
    .addr  (mem_addr),
    .wdata (wdata),
    .rdata (bias_rdata)
  );

  // Weight bank b holds neurons 4g+b
  for (genvar b = 0; b < LANES; b++) begin : g_wt_bank
    word_mem u_wt_mem (
      .clk   (clk),
      .we    (wt_we[b]),
      .addr  (mem_addr),
      .wdata (wdata),
      .rdata (wt_rdata[b])
    );
  end

  ////////////////////////////////////////////////////
  // Compute and output
  ////////////////////////////////////////////////////

  fc_sequencer u_sequencer (
    .clk        (clk),
    .rstn       (rstn),
    .compute_go (compute_go),
    .feat_count (feat_count),
    .out_count  (out_count),
    .feat_rdata (feat_rdata),
    .bias_rdata (bias_rdata),
    .wt_rdata   (wt_rdata),
    .rd_addr    (rd_addr),
    .run_finish (run_finish),
    .res        (res_if)
  );

  result_packer u_packer (
    .clk      (clk),
    .rstn     (rstn),
    .res      (res_if),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast),
    .max_idx  (max_idx)
  );

endmodule

/* hdl/fc_pkg.sv */
//////////////////////////////////////////////////
// Shared widths, memory sizes, data types and
// FSM encodings of the FC layer engine
//////////////////////////////////////////////////

package fc_pkg;

  // Datapath geometry
  localparam int LANES     = 4;
  localparam int DATA_W    = 8;
  localparam int WORD_W    = 32;
  localparam int ACC_W     = 28;
  localparam int MEM_DEPTH = 256;
  localparam int ADDR_W    = 8;
  localparam int SIZE_W    = 11;
  localparam int IDX_W     = 8;

  // Requantize: ReLU, shift, saturate
  localparam int FRAC_SHIFT = 6;
  localparam int SAT_MAX    = 127;

  typedef logic signed [DATA_W-1:0] act_t;
  typedef logic signed [ACC_W-1:0]  acc_t;
  typedef logic [WORD_W-1:0]        word_t;
  typedef logic [ADDR_W-1:0]        addr_t;
  typedef logic [SIZE_W-1:0]        size_t;
  typedef logic [IDX_W-1:0]         idx_t;

  typedef enum logic [1:0] {
    load_none, load_feat, load_bias, load_weight
  } load_mode_t;

  typedef enum logic [2:0] {
    seq_idle, seq_read, seq_feed, seq_drain, seq_bias, seq_handoff
  } seq_state_t;

endpackage

/* hdl/fc_result_if.sv */
//////////////////////////////////////////////////
// Group result handoff, four lane sums plus the
// matching bias word, sequencer to output packer
//////////////////////////////////////////////////

interface fc_result_if;
  import fc_pkg::*;

  logic  valid;
  logic  ready;
  acc_t  sums [LANES];
  word_t bias;
  // Marks the final group of the layer
  logic  last;

  modport sender (output valid, output sums, output bias, output last, input ready);
  modport receiver (input valid, input sums, input bias, input last, output ready);

endinterface

/* hdl/fc_sequencer.sv */
//////////////////////////////////////////////////
// Compute FSM: walks output groups and feature
// words, feeds the four MAC lanes and hands each
// finished group to the output packer
//////////////////////////////////////////////////

module fc_sequencer (
  input  logic          clk,
  input  logic          rstn,
  input  logic          compute_go,
  input  fc_pkg::size_t feat_count,
  input  fc_pkg::size_t out_count,
  input  fc_pkg::word_t feat_rdata,
  input  fc_pkg::word_t bias_rdata,
  input  fc_pkg::word_t wt_rdata [fc_pkg::LANES],
  output fc_pkg::addr_t rd_addr,
  output logic          run_finish,
  fc_result_if.sender   res
);
  import fc_pkg::*;

  seq_state_t state;
  addr_t      word_idx;
  addr_t      group;
  addr_t      wt_base;
  logic [1:0] byte_sel;
  logic       drain_cnt;
  logic       out_wait;
  word_t      feat_word;
  word_t      bias_word;
  logic       last_word;
  logic       last_group;
  logic       lane_en;
  logic       lane_first;
  act_t       feat_byte;
  wire acc_t  lane_acc [LANES];

  assign last_word  = (size_t'(word_idx) + size_t'(1)) == (feat_count >> 2);
  assign last_group = (size_t'(group) + size_t'(1)) == (out_count >> 2);

  // All memories share one read address. Feature word k is
  // fetched the cycle before its read cycle, so the read cycle
  // and the feed cycles can hold the weight address
  always_comb begin
    case (state)
      seq_read: rd_addr = wt_base + word_idx;
      seq_feed: begin
        if (byte_sel != 2'd3) begin
          rd_addr = wt_base + word_idx;
        end else if (last_word) begin
          rd_addr = '0;
        end else begin
          rd_addr = word_idx + addr_t'(1);
        end
      end
      seq_drain, seq_bias: rd_addr = group;
      default: rd_addr = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= seq_idle;
      word_idx  <= '0;
      group     <= '0;
      wt_base   <= '0;
      byte_sel  <= '0;
      drain_cnt <= 1'b0;
      out_wait  <= 1'b0;
    end else begin
      case (state)
        seq_idle: begin
          word_idx <= '0;
          group    <= '0;
          wt_base  <= '0;
          out_wait <= 1'b0;
          if (compute_go) begin
            state <= seq_read;
          end
        end
        seq_read: begin
          byte_sel <= '0;
          state    <= seq_feed;
        end
        seq_feed: begin
          byte_sel <= byte_sel + 2'd1;
          if (byte_sel == 2'd3) begin
            if (last_word) begin
              word_idx  <= '0;
              drain_cnt <= 1'b0;
              state     <= seq_drain;
            end else begin
              word_idx <= word_idx + addr_t'(1);
              state    <= seq_read;
            end
          end
        end
        // Two cycles for the lane pipeline to settle
        seq_drain: begin
          drain_cnt <= 1'b1;
          if (drain_cnt) begin
            state <= seq_bias;
          end
        end
        seq_bias: state <= seq_handoff;
        seq_handoff: begin
          if (res.ready) begin
            if (out_wait) begin
              // Last word has left the packer
              state <= seq_idle;
            end else if (last_group) begin
              out_wait <= 1'b1;
            end else begin
              group   <= group + addr_t'(1);
              wt_base <= wt_base + addr_t'(feat_count >> 2);
              state   <= seq_read;
            end
          end
        end
        default: state <= seq_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == seq_read) begin
      feat_word <= feat_rdata;
    end
    if (state == seq_bias) begin
      bias_word <= bias_rdata;
    end
  end

  // Every lane sees the same feature byte
  assign lane_en    = state == seq_feed;
  assign lane_first = lane_en && word_idx == '0 && byte_sel == 2'd0;
  assign feat_byte  = feat_word[DATA_W*byte_sel +: DATA_W];

  for (genvar l = 0; l < LANES; l++) begin : g_lane
    mac_lane u_lane (
      .clk    (clk),
      .rstn   (rstn),
      .en     (lane_en),
      .first  (lane_first),
      .feat   (feat_byte),
      .weight (wt_rdata[l][DATA_W*byte_sel +: DATA_W]),
      .acc    (lane_acc[l])
    );
  end

  assign res.valid  = state == seq_handoff && !out_wait;
  assign res.sums   = lane_acc;
  assign res.bias   = bias_word;
  assign res.last   = last_group;
  assign run_finish = state == seq_handoff && out_wait && res.ready;

endmodule

/* hdl/layer_config.sv */
//////////////////////////////////////////////////
// Command decode, layer size registers, sticky
// done flags and compute start
//////////////////////////////////////////////////

module layer_config (
  input  logic               clk,
  input  logic               rstn,
  input  logic [2:0]         command,
  input  logic               fc_start,
  input  fc_pkg::size_t      size,
  input  logic               load_finish,
  input  logic               run_finish,
  output fc_pkg::load_mode_t load_mode,
  output fc_pkg::size_t      feat_count,
  output fc_pkg::size_t      out_count,
  output logic               compute_go,
  output logic               f_done,
  output logic               b_done,
  output logic               w_done,
  output logic               fc_done
);
  import fc_pkg::*;

  load_mode_t next_mode;
  logic       computing;
  logic       w_done_q;
  logic       accept;

  // Lowest set command bit whose data is not loaded yet
  always_comb begin
    if (command[0] && !f_done) begin
      next_mode = load_feat;
    end else if (command[1] && !b_done) begin
      next_mode = load_bias;
    end else if (command[2] && !w_done) begin
      next_mode = load_weight;
    end else begin
      next_mode = load_none;
    end
  end

  assign accept = fc_start && load_mode == load_none && !computing;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      load_mode  <= load_none;
      computing  <= 1'b0;
      compute_go <= 1'b0;
      w_done_q   <= 1'b0;
      f_done     <= 1'b0;
      b_done     <= 1'b0;
      w_done     <= 1'b0;
      fc_done    <= 1'b0;
    end else begin
      // Start compute one cycle after the weights complete
      w_done_q   <= w_done;
      compute_go <= w_done && !w_done_q;
      if (accept) begin
        load_mode <= next_mode;
        fc_done   <= 1'b0;
      end else if (load_finish) begin
        load_mode <= load_none;
        case (load_mode)
          load_feat:   f_done <= 1'b1;
          load_bias:   b_done <= 1'b1;
          load_weight: begin
            w_done    <= 1'b1;
            computing <= 1'b1;
          end
          default: ;
        endcase
      end
      if (run_finish) begin
        computing <= 1'b0;
        fc_done   <= 1'b1;
      end
    end
  end

  // Sizes are captured with the load that defines them
  always_ff @(posedge clk) begin
    if (accept && next_mode == load_feat) begin
      feat_count <= size;
    end
    if (accept && next_mode == load_bias) begin
      out_count <= size;
    end
  end

endmodule

/* hdl/mac_lane.sv */
//////////////////////////////////////////////////
// Two-stage signed 8x8 multiply-accumulate lane
//////////////////////////////////////////////////

module mac_lane (
  input  logic         clk,
  input  logic         rstn,
  input  logic         en,
  input  logic         first,
  input  fc_pkg::act_t feat,
  input  fc_pkg::act_t weight,
  output fc_pkg::acc_t acc
);
  import fc_pkg::*;

  logic signed [2*DATA_W-1:0] prod;
  logic                       prod_vld;
  logic                       prod_first;

  // Stage 1 product
  always_ff @(posedge clk) begin
    if (!rstn) begin
      prod_vld   <= 1'b0;
      prod_first <= 1'b0;
    end else begin
      prod_vld   <= en;
      prod_first <= en && first;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      prod <= feat * weight;
    end
  end

  // Stage 2 accumulate, a first item restarts the sum
  always_ff @(posedge clk) begin
    if (prod_vld) begin
      acc <= prod_first ? acc_t'(prod) : acc + acc_t'(prod);
    end
  end

endmodule

/* hdl/result_packer.sv */
//////////////////////////////////////////////////
// Bias add, requantize and pack of four outputs,
// AXI-Stream master and running argmax
//////////////////////////////////////////////////

module result_packer (
  input  logic          clk,
  input  logic          rstn,
  fc_result_if.receiver res,
  output fc_pkg::word_t m_tdata,
  output logic          m_tvalid,
  input  logic          m_tready,
  output logic          m_tlast,
  output fc_pkg::idx_t  max_idx
);
  import fc_pkg::*;

  act_t  q [LANES];
  word_t packed_word;
  act_t  max_val;
  act_t  best_val;
  idx_t  best_idx;
  idx_t  group;
  logic  xfer;

  // ReLU, then shift and clamp to SAT_MAX
  function automatic act_t requant(acc_t sum, act_t bias);
    acc_t s;
    acc_t shifted;
    s       = sum + acc_t'(bias);
    shifted = s >>> FRAC_SHIFT;
    if (s < 0) begin
      return '0;
    end
    if (shifted > acc_t'(SAT_MAX)) begin
      return act_t'(SAT_MAX);
    end
    return act_t'(shifted);
  endfunction

  assign res.ready = !m_tvalid;
  assign xfer      = res.valid && res.ready;

  // Strictly greater keeps the first index on a tie
  always_comb begin
    best_val = max_val;
    best_idx = max_idx;
    for (int l = 0; l < LANES; l++) begin
      q[l] = requant(res.sums[l], act_t'(res.bias[DATA_W*l +: DATA_W]));
      packed_word[DATA_W*l +: DATA_W] = q[l];
      if (q[l] > best_val) begin
        best_val = q[l];
        best_idx = idx_t'(group * LANES + l);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
      group    <= '0;
      max_val  <= act_t'(-SAT_MAX - 1);
      max_idx  <= '0;
    end else if (xfer) begin
      m_tvalid <= 1'b1;
      m_tlast  <= res.last;
      group    <= group + idx_t'(1);
      max_val  <= best_val;
      max_idx  <= best_idx;
    end else if (m_tready) begin
      m_tvalid <= 1'b0;
      m_tlast  <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (xfer) begin
      m_tdata <= packed_word;
    end
  end

endmodule

/* hdl/stream_loader.sv */
//////////////////////////////////////////////////
// AXI-Stream slave writing feature, bias and
// weight words into the on-chip memories
//////////////////////////////////////////////////

module stream_loader (
  input  logic               clk,
  input  logic               rstn,
  input  fc_pkg::word_t      s_tdata,
  input  logic               s_tvalid,
  output logic               s_tready,
  input  fc_pkg::load_mode_t load_mode,
  input  fc_pkg::size_t      feat_count,
  input  fc_pkg::size_t      out_count,
  input  fc_pkg::addr_t      rd_addr,
  output logic               load_finish,
  output fc_pkg::addr_t      mem_addr,
  output fc_pkg::word_t      wdata,
  output logic               feat_we,
  output logic               bias_we,
  output logic [3:0]         wt_we
);
  import fc_pkg::*;

  addr_t      word_cnt;
  addr_t      wt_base;
  logic [1:0] bank;
  size_t      neuron;
  size_t      item_words;
  logic       beat;
  logic       last_word;
  logic       last_neuron;

  // Words per stream (feature, bias) or per neuron (weight)
  assign item_words  = (load_mode == load_bias) ? out_count >> 2 : feat_count >> 2;

  assign s_tready    = load_mode != load_none;
  assign beat        = s_tvalid && s_tready;
  assign last_word   = (size_t'(word_cnt) + size_t'(1)) == item_words;
  assign last_neuron = (neuron + size_t'(1)) == out_count;
  assign load_finish = beat && last_word && (load_mode != load_weight || last_neuron);

  // Each beat is written in the cycle it is accepted
  assign wdata   = s_tdata;
  assign feat_we = beat && load_mode == load_feat;
  assign bias_we = beat && load_mode == load_bias;
  assign wt_we   = (beat && load_mode == load_weight) ? 4'b0001 << bank : 4'b0000;

  // The sequencer owns the address bus while no load runs
  always_comb begin
    case (load_mode)
      load_none:   mem_addr = rd_addr;
      load_weight: mem_addr = wt_base + word_cnt;
      default:     mem_addr = word_cnt;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rstn || load_mode == load_none) begin
      word_cnt <= '0;
      wt_base  <= '0;
      bank     <= '0;
      neuron   <= '0;
    end else if (beat) begin
      if (last_word) begin
        word_cnt <= '0;
        neuron   <= neuron + size_t'(1);
        bank     <= bank + 2'd1;
        // Next bank row after each set of four neurons
        if (bank == 2'(LANES - 1)) begin
          wt_base <= wt_base + addr_t'(item_words);
        end
      end else begin
        word_cnt <= word_cnt + addr_t'(1);
      end
    end
  end

endmodule

/* hdl/word_mem.sv */
//////////////////////////////////////////////////
// Single-port word memory, synchronous write and
// registered read
//////////////////////////////////////////////////

module word_mem (
  input  logic          clk,
  input  logic          we,
  input  fc_pkg::addr_t addr,
  input  fc_pkg::word_t wdata,
  output fc_pkg::word_t rdata
);
  import fc_pkg::*;

  word_t mem [MEM_DEPTH];

  // Read returns the old contents on a write cycle
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

/* project.f */
+incdir+test
hdl/fc_pkg.sv
hdl/fc_result_if.sv
hdl/word_mem.sv
hdl/layer_config.sv
hdl/stream_loader.sv
hdl/mac_lane.sv
hdl/fc_sequencer.sv
hdl/result_packer.sv
hdl/fc_layer.sv
test/tb_fc_layer.sv

/* test/fc_model.svh */
//////////////////////////////////////////////////
// Reference model for the FC layer testbench:
// LFSR bit source, neuron sums, requantize and
// first-index argmax
//////////////////////////////////////////////////

`ifndef FC_MODEL_SVH
`define FC_MODEL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic lfsr_bit();
  logic fb;
  fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
  lfsr_state = {lfsr_state[30:0], fb};
  return fb;
endfunction

function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] r;
  r = '0;
  repeat (n) begin
    r = {r[30:0], lfsr_bit()};
  end
  return r;
endfunction

function automatic int neuron_sum(input int n, input int nf);
  int s;
  s = 0;
  for (int j = 0; j < nf; j++) begin
    s += int'(feat_v[j]) * int'(wt_v[n][j]);
  end
  return s;
endfunction

// ReLU, shift right, clamp at the ceiling
function automatic int requant_ref(input int s);
  if (s < 0) begin
    return 0;
  end
  if ((s >> FRAC_SHIFT) > SAT_MAX) begin
    return SAT_MAX;
  end
  return s >> FRAC_SHIFT;
endfunction

function automatic int neuron_out(input int n, input int nf);
  return requant_ref(neuron_sum(n, nf) + int'(bias_v[n]));
endfunction

// Lowest neuron of the group in the lowest byte
function automatic logic [31:0] expected_word(input int g, input int nf);
  logic [31:0] w;
  w = '0;
  for (int l = 0; l < 4; l++) begin
    w[8*l +: 8] = 8'(neuron_out(4*g + l, nf));
  end
  return w;
endfunction

function automatic int argmax_ref(input int nf, input int no);
  int best;
  int idx;
  int v;
  best = -1;
  idx  = 0;
  for (int n = 0; n < no; n++) begin
    v = neuron_out(n, nf);
    if (v > best) begin
      best = v;
      idx  = n;
    end
  end
  return idx;
endfunction

`endif

/* test/tb_fc_layer.sv */
//////////////////////////////////////////////////
// FC layer engine testbench with clock, reset,
// stream drivers, output collector and directed
// tests
//////////////////////////////////////////////////

module tb_fc_layer;
  import fc_pkg::*;

  logic       clk;
  logic       rstn;
  word_t      s_tdata;
  logic       s_tvalid;
  logic       s_tready;
  word_t      m_tdata;
  logic       m_tvalid;
  logic       m_tready;
  logic       m_tlast;
  logic [2:0] command;
  logic       fc_start;
  size_t      size;
  logic       f_done;
  logic       b_done;
  logic       w_done;
  logic       fc_done;
  idx_t       max_idx;

  int          errors;
  int          checks;
  logic [31:0] lfsr_state;

  // Test data indexed by element j
  byte   feat_v [256];
  byte   wt_v [32][256];
  byte   bias_v [32];
  word_t load_q [$];
  word_t got_q [$];
  logic  got_last [$];

  `include "fc_model.svh"

  fc_layer UUT (
    .clk      (clk),
    .rstn     (rstn),
    .s_tdata  (s_tdata),
    .s_tvalid (s_tvalid),
    .s_tready (s_tready),
    .m_tdata  (m_tdata),
    .m_tvalid (m_tvalid),
    .m_tready (m_tready),
    .m_tlast  (m_tlast),
    .command  (command),
    .fc_start (fc_start),
    .size     (size),
    .f_done   (f_done),
    .b_done   (b_done),
    .w_done   (w_done),
    .fc_done  (fc_done),
    .max_idx  (max_idx)
  );

  always #5 clk = ~clk;

  ////////////////////////////////////////////////////
  // Checking and drivers
  ////////////////////////////////////////////////////

  task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task report_timeout(input string what);
    errors++;
    $display("Timeout while waiting for %s", what);
  endtask

  task apply_reset();
    @(posedge clk);
    rstn     <= 1'b0;
    fc_start <= 1'b0;
    s_tvalid <= 1'b0;
    m_tready <= 1'b1;
    command  <= '0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
  endtask

  task issue_command(input logic [2:0] cmd, input int sz);
    @(posedge clk);
    command  <= cmd;
    size     <= size_t'(sz);
    fc_start <= 1'b1;
    @(posedge clk);
    fc_start <= 1'b0;
  endtask

  // Kind selects features (0), biases (1) or weights neuron by neuron (2)
  task pack_stream(input int kind, input int nf, input int no);
    load_q.delete();
    if (kind == 0) begin
      for (int k = 0; k < nf / 4; k++) begin
        load_q.push_back({feat_v[4*k+3], feat_v[4*k+2], feat_v[4*k+1], feat_v[4*k]});
      end
    end else if (kind == 1) begin
      for (int k = 0; k < no / 4; k++) begin
        load_q.push_back({bias_v[4*k+3], bias_v[4*k+2], bias_v[4*k+1], bias_v[4*k]});
      end
    end else begin
      for (int n = 0; n < no; n++) begin
        for (int k = 0; k < nf / 4; k++) begin
          load_q.push_back({wt_v[n][4*k+3], wt_v[n][4*k+2], wt_v[n][4*k+1], wt_v[n][4*k]});
        end
      end
    end
  endtask

  task stream_load(input logic [2:0] cmd, input int sz, input bit gaps);
    int t;
    issue_command(cmd, sz);
    foreach (load_q[i]) begin
      if (gaps && lfsr_bit()) begin
        s_tvalid <= 1'b0;
        @(posedge clk);
      end
      s_tdata  <= load_q[i];
      s_tvalid <= 1'b1;
      t = 0;
      @(negedge clk);
      while (!s_tready && t < 100) begin
        @(negedge clk);
        t++;
      end
      if (!s_tready) begin
        report_timeout("s_tready during a load");
        @(posedge clk);
        s_tvalid <= 1'b0;
        return;
      end
      @(posedge clk);
    end
    s_tvalid <= 1'b0;
  endtask

  // Words are taken at the negedge before the accepting edge
  task collect_outputs(input bit stall);
    int t;
    got_q.delete();
    got_last.delete();
    t = 0;
    while (!fc_done && t < 3000) begin
      @(posedge clk);
      m_tready <= stall ? lfsr_bit() : 1'b1;
      @(negedge clk);
      if (m_tvalid && m_tready) begin
        got_q.push_back(m_tdata);
        got_last.push_back(m_tlast);
      end
      t++;
    end
    if (!fc_done) begin
      report_timeout("fc_done at the end of the run");
    end
  endtask

  task check_outputs(input string name, input int nf, input int no);
    check_value({name, " word count"}, no / 4, got_q.size());
    foreach (got_q[g]) begin
      check_value({name, " data"}, expected_word(g, nf), got_q[g]);
      check_value({name, " tlast"}, g == no / 4 - 1, got_last[g]);
    end
    check_value({name, " tvalid idle"}, 0, m_tvalid);
    check_value({name, " max_idx"}, argmax_ref(nf, no), max_idx);
  endtask

  task run_layer(input string name, input int nf, input int no, input bit stall);
    apply_reset();
    pack_stream(0, nf, no);
    stream_load(3'b001, nf, stall);
    pack_stream(1, nf, no);
    stream_load(3'b010, no, stall);
    pack_stream(2, nf, no);
    stream_load(3'b100, nf, stall);
    collect_outputs(stall);
    check_outputs(name, nf, no);
  endtask

  ////////////////////////////////////////////////////
  // Test data
  ////////////////////////////////////////////////////

  task fill_small();
    for (int n = 0; n < 4; n++) begin
      bias_v[n] = byte'(5*n - 8);
      for (int j = 0; j < 8; j++) begin
        feat_v[j]    = byte'(4*j + 3);
        wt_v[n][j]   = byte'(3*n + j - 2);
      end
    end
  endtask

  // Neuron 0 saturates and neuron 1 is driven negative
  task fill_random(input int nf, input int no);
    for (int j = 0; j < nf; j++) begin
      feat_v[j] = byte'(rand_bits(8));
    end
    for (int n = 0; n < no; n++) begin
      bias_v[n] = byte'(rand_bits(8));
      for (int j = 0; j < nf; j++) begin
        wt_v[n][j] = byte'(rand_bits(8));
      end
    end
    for (int j = 0; j < nf; j++) begin
      wt_v[0][j] = feat_v[j];
      wt_v[1][j] = ~feat_v[j];
    end
  endtask

  // Neurons 2 and 5 share weights and tie for the maximum
  task fill_tie();
    for (int n = 0; n < 8; n++) begin
      bias_v[n] = 0;
      for (int j = 0; j < 8; j++) begin
        feat_v[j]  = byte'(j + 1);
        wt_v[n][j] = (n == 2 || n == 5) ? byte'(j) : 0;
      end
    end
  endtask

  ////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////

  task test_load_handshake();
    fill_small();
    apply_reset();
    @(negedge clk);
    check_value("load_handshake f_done at reset", 0, f_done);
    pack_stream(0, 8, 4);
    stream_load(3'b001, 8, 1'b0);
    @(negedge clk);
    check_value("load_handshake f_done", 1, f_done);
    check_value("load_handshake feature s_tready", 0, s_tready);
    // A feature command with f_done set opens no load
    issue_command(3'b001, 8);
    repeat (3) begin
      @(negedge clk);
      check_value("load_handshake repeat s_tready", 0, s_tready);
    end
    pack_stream(1, 8, 4);
    stream_load(3'b010, 4, 1'b0);
    @(negedge clk);
    check_value("load_handshake b_done", 1, b_done);
    check_value("load_handshake bias s_tready", 0, s_tready);
    pack_stream(2, 8, 4);
    stream_load(3'b100, 8, 1'b0);
    @(negedge clk);
    check_value("load_handshake w_done", 1, w_done);
    check_value("load_handshake weight s_tready", 0, s_tready);
    collect_outputs(1'b0);
    check_outputs("load_handshake", 8, 4);
  endtask

  task test_single_group();
    fill_small();
    run_layer("single_group", 8, 4, 1'b0);
  endtask

  task test_multi_group();
    fill_random(16, 12);
    run_layer("multi_group", 16, 12, 1'b0);
  endtask

  // Same data as the multi group run
  task test_back_pressure();
    run_layer("back_pressure", 16, 12, 1'b1);
  endtask

  task test_argmax_tie();
    fill_tie();
    run_layer("argmax_tie", 8, 8, 1'b0);
  endtask

  initial begin
    clk        = 1'b0;
    rstn       = 1'b0;
    s_tdata    = '0;
    s_tvalid   = 1'b0;
    m_tready   = 1'b1;
    command    = '0;
    fc_start   = 1'b0;
    size       = '0;
    errors     = 0;
    checks     = 0;
    lfsr_state = 32'hb27b;

    test_load_handshake();
    test_single_group();
    test_multi_group();
    test_back_pressure();
    test_argmax_tie();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
